// File: ca_upsampler.f
hdl/ca_code_pkg.sv
hdl/sample_pkg.sv
hdl/ca_chip_clock.sv
hdl/ca_shift_counter.sv
hdl/ca_generator.sv
hdl/ca_upsampler.sv
testbench/ca_upsampler_chk.sv
testbench/tb_ca_upsampler.sv

// File: Bender.yml
package:
  name: ca_upsampler

dependencies: {}

sources:
  # Packages first, then the modules bottom up.
  - files:
      - hdl/ca_code_pkg.sv
      - hdl/sample_pkg.sv
      - hdl/ca_chip_clock.sv
      - hdl/ca_shift_counter.sv
      - hdl/ca_generator.sv
      - hdl/ca_upsampler.sv

  # Simulation only.
  - target: test
    files:
      - testbench/ca_upsampler_chk.sv
      - testbench/tb_ca_upsampler.sv

// File: testbench/tb_ca_upsampler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ca_upsampler;

   localparam int unsigned code_period = sample_pkg::code_period;
   localparam int unsigned spc = sample_pkg::samples_per_chip;
   localparam int unsigned cs_width = sample_pkg::cs_width;
   localparam int unsigned ci_width = ca_code_pkg::chip_index_width;
   localparam int unsigned prn_width = ca_code_pkg::prn_width;

   // A full period plus a little, so every run crosses the wrap.
   localparam int unsigned run_len = code_period + 64;
   localparam int unsigned rand_len = 3000;
   localparam int unsigned seek_max_offset = 1000;

   // Four full runs, the gap run, two short seeks and one seek through the wrap.
   localparam int unsigned test_cycles = 4 * run_len + rand_len + 2 * seek_max_offset
                                         + code_period + 200;
   localparam int unsigned timeout_cycles = test_cycles + test_cycles / 8;

   logic                 clk;
   logic                 reset;
   logic                 enable;
   logic [prn_width-1:0] prn;
   logic                 seek_en;
   logic [cs_width-1:0]  seek_target;
   logic [cs_width-1:0]  code_shift;
   logic                 out;
   logic                 seeking;
   logic                 ca_clk;
   logic [ci_width-1:0]  ca_code_shift;

   int seed = 9095;
   int cycles = 0;
   int fail_count = 0;

   // Expected chips of the current PRN, one per chip index.
   logic code_table [0:ca_code_pkg::code_length-1];

   // Model of the sample position and of the delayed advance.
   int   m_shift = 0;
   logic m_adv = 1'b0;

   ca_upsampler DUT (
      .clk           (clk),
      .reset         (reset),
      .enable        (enable),
      .prn           (prn),
      .seek_en       (seek_en),
      .seek_target   (seek_target),
      .code_shift    (code_shift),
      .out           (out),
      .seeking       (seeking),
      .ca_clk        (ca_clk),
      .ca_code_shift (ca_code_shift)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Chip n of the C/A code, straight from the G1/G2 recurrence.
   function automatic logic ca_chip(input logic [prn_width-1:0] prn_sel, input int n);
      logic [10:1] g1;
      logic [10:1] g2;
      logic [7:0]  pair;
      int          prn_num;
      int          stage_a;
      int          stage_b;
      logic        g1_new;
      logic        g2_new;
      prn_num = (prn_sel == 0) ? 32 : int'(prn_sel);
      pair = ca_code_pkg::g2_taps[prn_num - 1];
      stage_a = pair[7:4];
      stage_b = pair[3:0];
      g1 = '1;
      g2 = '1;
      for (int k = 0; k < n; k++) begin
         g1_new = g1[3] ^ g1[10];
         g2_new = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         g1 = {g1[9:1], g1_new};
         g2 = {g2[9:1], g2_new};
      end
      return g1[10] ^ g2[stage_a] ^ g2[stage_b];
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first failure.");
   endtask

   task automatic check_shift(input string name, input logic [cs_width-1:0] actual,
                              input logic [cs_width-1:0] expected);
      if (actual !== expected) begin
         fail_count++;
         abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         fail_count++;
         abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %b, got %b",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_index(input string name, input logic [ci_width-1:0] actual,
                              input logic [ci_width-1:0] expected);
      if (actual !== expected) begin
         fail_count++;
         abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                             $time, name, expected, actual));
      end
   endtask

   // PRN 1 starts with octal 1440 in the first ten chips.
   task automatic check_reference;
      logic [9:0] first_chips;
      for (int k = 0; k < 10; k++) begin
         first_chips[9 - k] = ca_chip(1, k);
      end
      if (first_chips !== 10'b1100100000) begin
         abort_run("The reference code model gives the wrong first chips for PRN 1.");
      end
   endtask

   task automatic build_code_table(input logic [prn_width-1:0] prn_sel);
      for (int n = 0; n < ca_code_pkg::code_length; n++) begin
         code_table[n] = ca_chip(prn_sel, n);
      end
   endtask

   // PRN is only taken up at reset, so it is set inside the reset window.
   task automatic apply_reset(input logic [prn_width-1:0] prn_sel);
      @(negedge clk);
      reset = 1'b1;
      enable = 1'b0;
      seek_en = 1'b0;
      prn = prn_sel;
      build_code_table(prn_sel);
      repeat (5) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic run_enabled(input int n);
      enable = 1'b1;
      repeat (n) @(negedge clk);
      enable = 1'b0;
   endtask

   // About two samples in three are valid.
   task automatic run_random(input int n);
      repeat (n) begin
         enable = ($random(seed) % 3) != 0;
         @(negedge clk);
      end
      enable = 1'b0;
   endtask

   // Behind means the seek runs through the wrap.
   task automatic seek_to(input int offset, input bit behind);
      int target;
      enable = 1'b0;
      repeat (3) @(negedge clk);
      if (behind) begin
         target = (m_shift + code_period - offset) % code_period;
      end else begin
         target = (m_shift + offset) % code_period;
      end
      seek_target = cs_width'(target);
      seek_en = 1'b1;
      do begin
         @(negedge clk);
      end while (seeking);
      // The last step lands on the edge after seeking falls.
      @(negedge clk);
      check_shift("code_shift at seek end", code_shift, cs_width'(target));
      check_bit("seeking at seek end", seeking, 1'b0);
      check_bit("out at seek target", out, code_table[target / spc]);
      @(negedge clk);
      check_shift("code_shift held after seek", code_shift, cs_width'(target));
      seek_en = 1'b0;
   endtask

   // Checks the pre-edge outputs, then steps the model.
   always @(posedge clk) begin : compare
      int   next_pos;
      logic exp_seek;
      if (reset) begin
         m_shift = 0;
         m_adv = 1'b0;
      end else begin
         next_pos = (m_shift == code_period - 1) ? 0 : m_shift + 1;
         exp_seek = seek_en && (m_shift != seek_target) && !(m_adv && next_pos == seek_target);
         check_shift("code_shift", code_shift, cs_width'(m_shift));
         check_bit("seeking", seeking, exp_seek);
         check_bit("ca_clk", ca_clk, m_adv && (next_pos % spc == 0));
         check_bit("out", out, code_table[m_shift / spc]);
         check_index("ca_code_shift", ca_code_shift, ci_width'(m_shift / spc));
         if (m_adv) begin
            m_shift = next_pos;
         end
         m_adv = seek_en ? exp_seek : enable;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         abort_run($sformatf("Timeout: the tests did not finish within %0d cycles.", cycles));
      end
   end

   initial begin
      int offset;
      reset = 1'b1;
      enable = 1'b0;
      prn = 5'd1;
      seek_en = 1'b0;
      seek_target = '0;
      check_reference();

      // Continuous samples for PRN 1 over a full period and the wrap.
      apply_reset(5'd1);
      run_enabled(run_len);

      // Gaps in the sample stream.
      run_random(rand_len);

      // Two seeks ahead, then one through the wrap.
      repeat (2) begin
         offset = 16 + ({$random(seed)} % (seek_max_offset - 15));
         seek_to(offset, 1'b0);
      end
      offset = 16 + ({$random(seed)} % (seek_max_offset - 15));
      seek_to(offset, 1'b1);

      // Other tap pairs. PRN 32 is the value 0.
      apply_reset(5'd7);
      run_enabled(run_len);
      apply_reset(5'd19);
      run_enabled(run_len);
      apply_reset(5'd0);
      run_enabled(run_len);

      repeat (4) @(negedge clk);
      if (fail_count == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("CHECKS FAILED");
         $fatal(1, "Failures were counted.");
      end
   end

endmodule

`default_nettype wire

// File: testbench/ca_upsampler_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ca_upsampler_chk (
   input logic                            clk,
   input logic                            reset,
   input logic [sample_pkg::cs_width-1:0] code_shift,
   input logic [sample_pkg::cs_width-1:0] seek_target,
   input logic                            seek_en,
   input logic                            seek_active,
   input logic                            wrap,
   input sample_pkg::counter_mode_t       mode
);

   // Position stays inside one code period.
   a_shift_range: assert property (@(posedge clk) disable iff (reset)
      code_shift <= sample_pkg::max_code_shift)
      else $error("code_shift is above the last sample position");

   // The step after the last position lands on 0.
   a_wrap_to_zero: assert property (@(posedge clk) disable iff (reset)
      wrap |=> code_shift == '0)
      else $error("code_shift did not return to 0 after wrap");

   // Seek steps only while a seek is requested, and never away from the target.
   a_seek_needs_en: assert property (@(posedge clk) disable iff (reset)
      mode == sample_pkg::mode_seek |-> seek_en && code_shift != seek_target)
      else $error("counter in seek mode with seek_en low or on the target");

   // A cycle on the target ends the seek, so the counter stays there.
   a_stop_at_target: assert property (@(posedge clk) disable iff (reset)
      (seek_en && code_shift == seek_target) |=> !seek_active)
      else $error("seek_active high after a cycle on the target");

endmodule

bind ca_shift_counter ca_upsampler_chk u_chk (
   .clk         (clk),
   .reset       (reset),
   .code_shift  (code_shift),
   .seek_target (seek_target),
   .seek_en     (seek_en),
   .seek_active (seek_active),
   .wrap        (wrap),
   .mode        (mode)
);

`default_nettype wire

// File: hdl/ca_upsampler.sv
`timescale 1ns/1ps
`default_nettype none

module ca_upsampler #(
   parameter int unsigned acc_width = 16,
   parameter int unsigned phase_inc = 4096
) (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     enable,
   input  logic [ca_code_pkg::prn_width-1:0]         prn,
   input  logic                                     seek_en,
   input  logic [sample_pkg::cs_width-1:0]           seek_target,
   output logic [sample_pkg::cs_width-1:0]           code_shift,
   output logic                                     out,
   output logic                                     seeking,
   // Debug taps.
   output logic                                     ca_clk,
   output logic [ca_code_pkg::chip_index_width-1:0] ca_code_shift
);

   // Advance request before and after the timing register.
   logic advance_req;
   logic advance;

   // Counter results.
   logic seek_active;
   logic wrap;

   // Chip clock result.
   logic chip_strobe;

   // Generator chip index.
   logic [ca_code_pkg::chip_index_width-1:0] chip_index;

   // Valid samples drive the counter, unless a seek owns it.
   assign advance_req = seek_en ? seek_active : enable;

   // One register stage on the advance path.
   always_ff @(posedge clk) begin
      if (reset) begin
         advance <= 1'b0;
      end else begin
         advance <= advance_req;
      end
   end

   // Sample position counter.
   ca_shift_counter u_shift_counter (
      .clk         (clk),
      .reset       (reset),
      .advance     (advance),
      .seek_en     (seek_en),
      .seek_target (seek_target),
      .code_shift  (code_shift),
      .seek_active (seek_active),
      .wrap        (wrap)
   );

   // Chip rate clock, running on the same advance as the counter.
   ca_chip_clock #(
      .acc_width (acc_width),
      .phase_inc (phase_inc)
   ) u_chip_clock (
      .clk         (clk),
      .reset       (reset),
      .advance     (advance),
      .wrap        (wrap),
      .chip_strobe (chip_strobe)
   );

   // Gold code generator, stepped per chip and realigned per period.
   ca_generator u_generator (
      .clk         (clk),
      .reset       (reset),
      .chip_strobe (chip_strobe),
      .wrap        (wrap),
      .prn         (prn),
      .out         (out),
      .chip_index  (chip_index)
   );

   assign seeking       = seek_active;
   assign ca_clk        = chip_strobe;
   assign ca_code_shift = chip_index;

endmodule

`default_nettype wire

// File: hdl/ca_generator.sv
`timescale 1ns/1ps
`default_nettype none

module ca_generator (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    chip_strobe,
   input  logic                                    wrap,
   input  logic [ca_code_pkg::prn_width-1:0]        prn,
   output logic                                    out,
   output logic [ca_code_pkg::chip_index_width-1:0] chip_index
);

   // G1 and G2 shift registers, numbered as stages 1 to 10.
   logic [10:1] g1;
   logic [10:1] g2;

   // PRN in use for the current code period.
   logic [ca_code_pkg::prn_width-1:0] prn_q;

   // Row of the tap table. PRN 32 (value 0) wraps to row 31.
   logic [ca_code_pkg::prn_width-1:0] tap_row;

   // Selected G2 stage pair.
   logic [7:0] tap_pair;
   logic [3:0] tap_a;
   logic [3:0] tap_b;

   // Feedback bits.
   logic g1_fb;
   logic g2_fb;

   // Index of the chip after this one.
   logic [ca_code_pkg::chip_index_width-1:0] next_index;

   assign tap_row  = prn_q - ca_code_pkg::prn_width'(1);
   assign tap_pair = ca_code_pkg::g2_taps[tap_row];
   assign tap_a    = tap_pair[7:4];
   assign tap_b    = tap_pair[3:0];

   // G1 polynomial 1 + x^3 + x^10.
   assign g1_fb = g1[3] ^ g1[10];

   // G2 polynomial 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10.
   assign g2_fb = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];

   // Stay inside one period even if a strobe came without a wrap.
   assign next_index = (chip_index == ca_code_pkg::chip_index_width'(ca_code_pkg::code_length - 1))
                       ? '0 : chip_index + 1'b1;

   // C/A chip is G1 out mixed with the phase-selected G2 pair.
   assign out = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Wrap has priority over a strobe on the same edge.
   always_ff @(posedge clk) begin
      if (reset || wrap) begin
         g1         <= '1;
         g2         <= '1;
         chip_index <= '0;
      end else if (chip_strobe) begin
         g1         <= {g1[9:1], g1_fb};
         g2         <= {g2[9:1], g2_fb};
         chip_index <= next_index;
      end
   end

   // PRN changes only take effect at a code boundary.
   always_ff @(posedge clk) begin
      if (reset || wrap) begin
         prn_q <= prn;
      end
   end

endmodule

`default_nettype wire

// File: hdl/ca_shift_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ca_shift_counter (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            advance,
   input  logic                            seek_en,
   input  logic [sample_pkg::cs_width-1:0] seek_target,
   output logic [sample_pkg::cs_width-1:0] code_shift,
   output logic                            seek_active,
   output logic                            wrap
);

   // Next sample position, modulo the code period.
   logic [sample_pkg::cs_width-1:0] next_shift;

   // What the counter does this cycle.
   sample_pkg::counter_mode_t mode;

   // Seek termination terms.
   logic at_last;
   logic target_upcoming;
   logic target_reached;

   assign at_last = (code_shift == sample_pkg::max_code_shift);

   assign next_shift = at_last ? '0 : code_shift + 1'b1;

   // Wrap on the last position of the period when advancing.
   assign wrap = at_last & advance;

   // The target arrives at the next edge if it is the next value
   // and the delayed advance is already high.
   assign target_upcoming = (next_shift == seek_target) & advance;

   // Already sitting on the target.
   assign target_reached = (code_shift == seek_target);

   // Keep requesting advances until the target is reached or about to be.
   // The one-cycle advance delay is covered by the upcoming term.
   assign seek_active = seek_en & ~(target_upcoming | target_reached);

   // Classify the cycle.
   always_comb begin
      if (!advance) begin
         mode = sample_pkg::mode_hold;
      end else if (seek_en) begin
         mode = sample_pkg::mode_seek;
      end else begin
         mode = sample_pkg::mode_track;
      end
   end

   // Sample position register.
   always_ff @(posedge clk) begin
      if (reset) begin
         code_shift <= '0;
      end else begin
         case (mode)
            // Seek steps one sample per cycle, same as tracking.
            sample_pkg::mode_track, sample_pkg::mode_seek: code_shift <= next_shift;
            default:                                       code_shift <= code_shift;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/ca_chip_clock.sv
`timescale 1ns/1ps
`default_nettype none

module ca_chip_clock #(
   parameter int unsigned acc_width = 16,
   parameter int unsigned phase_inc = 4096
) (
   input  logic clk,
   input  logic reset,
   input  logic advance,
   input  logic wrap,
   output logic chip_strobe
);

   // Increment sized to the accumulator plus its carry bit.
   localparam logic [acc_width:0] inc_ext = (acc_width + 1)'(phase_inc);

   // The accumulator must carry exactly once per chip.
   if (phase_inc * sample_pkg::samples_per_chip != (64'd1 << acc_width)) begin : g_rate_check
      $error("ca_chip_clock: phase_inc does not give one carry per chip");
   end

   // Phase accumulator.
   logic [acc_width-1:0] acc;

   // Sum with the carry in the top bit.
   logic [acc_width:0] sum;

   assign sum = {1'b0, acc} + inc_ext;

   // Carry on an advancing cycle marks the first sample of a new chip.
   assign chip_strobe = advance & sum[acc_width];

   // Wrap realigns the phase with the code period.
   always_ff @(posedge clk) begin
      if (reset || wrap) begin
         acc <= '0;
      end else if (advance) begin
         acc <= sum[acc_width-1:0];
      end
   end

endmodule

`default_nettype wire

// File: hdl/sample_pkg.sv
`default_nettype none

package sample_pkg;

   // Width of the code-shift sample position.
   localparam int unsigned cs_width = 14;

   // Samples per C/A chip at the receiver sample rate.
   localparam int unsigned samples_per_chip = 16;

   // Samples in one code period (1023 chips of 16 samples).
   localparam int unsigned code_period = 16368;

   // Last sample position before the counter wraps.
   localparam logic [cs_width-1:0] max_code_shift = cs_width'(code_period - 1);

   // What the shift counter does in the current cycle.
   // Hold means no advance.
   // Track means an advance on a valid sample.
   // Seek means an advance requested by the seek logic.
   typedef enum logic [1:0] {
      mode_hold,
      mode_track,
      mode_seek
   } counter_mode_t;

endpackage

`default_nettype wire

// File: hdl/ca_code_pkg.sv
`default_nettype none

package ca_code_pkg;

   // PRN select width. The value 0 selects PRN 32.
   localparam int unsigned prn_width = 5;

   // Chips in one C/A code period.
   localparam int unsigned code_length = 1023;

   // Wide enough for chip indices 0 to 1022.
   localparam int unsigned chip_index_width = 10;

   // G2 phase-select stage pairs, indexed by PRN minus one.
   // Upper nibble is the first stage, lower nibble the second.
   // Stage numbers run from 1 to 10 (hex A is stage 10).
   localparam logic [7:0] g2_taps [0:31] = '{
      8'h26, 8'h37, 8'h48, 8'h59,
      8'h19, 8'h2A, 8'h18, 8'h29,
      8'h3A, 8'h23, 8'h34, 8'h56,
      8'h67, 8'h78, 8'h89, 8'h9A,
      8'h14, 8'h25, 8'h36, 8'h47,
      8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8A,
      8'h16, 8'h27, 8'h38, 8'h49
   };

endpackage

`default_nettype wire
